// File: common/rtc_pkg.sv
package rtc_pkg;

    // one time byte, seen as a plain binary count or as two BCD digits.
    typedef union packed {
        logic [7:0] bin;
        struct packed {
            logic [3:0] tens;
            logic [3:0] ones;
        } bcd;
    } time_byte_t;

    localparam int NUM_FIELDS = 3;                  // seconds, minutes, hours.
    localparam logic [7:0] FIELD_MAX [NUM_FIELDS] = '{8'd59, 8'd59, 8'd23};

    localparam logic [6:0] REG_SECONDS       = 7'h00;
    localparam logic [6:0] REG_ALARM_SECONDS = 7'h01;
    localparam logic [6:0] REG_MINUTES       = 7'h02;
    localparam logic [6:0] REG_ALARM_MINUTES = 7'h03;
    localparam logic [6:0] REG_HOURS         = 7'h04;
    localparam logic [6:0] REG_ALARM_HOURS   = 7'h05;
    localparam logic [6:0] REG_A             = 7'h0A;
    localparam logic [6:0] REG_B             = 7'h0B;
    localparam logic [6:0] REG_C             = 7'h0C;
    localparam logic [6:0] REG_D             = 7'h0D;

    localparam logic [7:0] REG_D_VALUE = 8'h80;     // battery good.

    localparam int UPDATE_HZ    = 800;
    localparam int PERIODIC_HZ  = 8192;
    localparam int UPDATE_TICKS = 800;              // 800 Hz ticks per second.
    localparam int UPDATE_LEAD  = 4;                // first countdown after reset or halt.

    localparam logic [1:0] ALARM_WILDCARD = 2'b11;  // top bits of a don't-care alarm.
    localparam logic [1:0] DIVIDER_STOP   = 2'b11;  // divider bits 6:5 that stop the clock.

endpackage

// File: src/rtc_tick_gen.sv
`timescale 1ns/100ps

module rtc_tick_gen import rtc_pkg::*; #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick_800,
    output logic tick_8192
);

    localparam int ACC_W = $clog2(CLK_HZ + PERIODIC_HZ + 1);
    localparam int RATE_HZ [2] = '{UPDATE_HZ, PERIODIC_HZ};

    logic [1:0] tick;

    // the sum stays below CLK_HZ, so the average tick rate is exact.
    for (genvar r = 0; r < 2; r++) begin : g_acc
        logic [ACC_W-1:0] sum;
        logic [ACC_W-1:0] sum_next;
        logic tick_q;

        assign sum_next = sum + ACC_W'(RATE_HZ[r]);
        assign tick[r] = tick_q;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                sum <= '0;
                tick_q <= 1'b0;
            end else if (sum_next >= ACC_W'(CLK_HZ)) begin
                sum <= sum_next - ACC_W'(CLK_HZ);   // wrap, keep the remainder.
                tick_q <= 1'b1;
            end else begin
                sum <= sum_next;
                tick_q <= 1'b0;
            end
        end
    end

    assign tick_800 = tick[0];
    assign tick_8192 = tick[1];

    a_clk_rate: assert property (@(posedge clk) disable iff (!rst_n) CLK_HZ >= PERIODIC_HZ)
        else $error("system clock slower than the periodic tick rate");

endmodule

// File: src/rtc_update_ctrl.sv
`timescale 1ns/100ps

module rtc_update_ctrl import rtc_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic halt,
    input  logic tick_800,
    output logic second_start,
    output logic update_busy
);

    localparam logic [2:0] ST_UPDATE_START     = 3'd0;
    localparam logic [2:0] ST_UPDATE_PROGRESS  = 3'd1;
    localparam logic [2:0] ST_SECOND_START     = 3'd2;
    localparam logic [2:0] ST_SECOND_PROGRESS  = 3'd3;
    localparam logic [2:0] ST_STOPPED          = 3'd4;
    localparam int CNT_W = $clog2(UPDATE_TICKS);

    logic [2:0] state;
    logic [CNT_W-1:0] countdown;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_UPDATE_START;
        end else if (halt) begin
            state <= ST_STOPPED;
        end else begin
            case (state)
                ST_STOPPED:         state <= ST_UPDATE_START;
                ST_UPDATE_START:    state <= ST_UPDATE_PROGRESS;
                ST_UPDATE_PROGRESS: if (countdown == '0) state <= ST_SECOND_START;
                ST_SECOND_START:    state <= ST_SECOND_PROGRESS;
                ST_SECOND_PROGRESS: if (countdown == CNT_W'(1)) state <= ST_UPDATE_START;
                default:            state <= ST_STOPPED;
            endcase
        end
    end

    // one second is UPDATE_TICKS ticks from zero to zero.
    always_ff @(posedge clk) begin
        if (!rst_n || halt) begin
            countdown <= CNT_W'(UPDATE_LEAD);
        end else if (tick_800) begin
            if (countdown == '0) begin
                countdown <= CNT_W'(UPDATE_TICKS - 1);
            end else begin
                countdown <= countdown - 1'b1;
            end
        end
    end

    assign second_start = (state == ST_SECOND_START) && !halt;  // a halt just raised wins.
    assign update_busy = (state == ST_UPDATE_PROGRESS) || (state == ST_SECOND_START);

    a_second_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        second_start |-> !halt ##1 !second_start)
        else $error("second_start held or raised during halt");

endmodule

// File: src/rtc_field_counter.sv
`timescale 1ns/100ps

module rtc_field_counter import rtc_pkg::*; #(
    parameter logic [7:0] MAX_BIN = 8'd59
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       binary_mode,
    input  logic       step,
    input  logic       load,
    input  time_byte_t load_data,
    output time_byte_t value,
    output time_byte_t next_value,
    output logic       carry
);

    localparam logic [3:0] MAX_TENS = 4'(MAX_BIN / 10);
    localparam logic [3:0] MAX_ONES = 4'(MAX_BIN % 10);

    logic at_max;

    // out of range values also count as the limit, so a bad load still wraps.
    assign at_max = binary_mode ? (value.bin >= MAX_BIN) :
                    (value.bcd.tens > MAX_TENS) ||
                    (value.bcd.tens == MAX_TENS && value.bcd.ones >= MAX_ONES);

    always_comb begin
        if (at_max) begin
            next_value.bin = 8'h00;
        end else if (!binary_mode && value.bcd.ones >= 4'd9) begin
            next_value.bcd.tens = value.bcd.tens + 4'd1;    // ones digit rolls into tens.
            next_value.bcd.ones = 4'd0;
        end else begin
            next_value.bin = value.bin + 8'd1;
        end
    end

    assign carry = step && at_max;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (load) begin
            value <= load_data;     // host load beats a step.
        end else if (step) begin
            value <= next_value;
        end
    end

    a_carry_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        carry |-> step ##1 (value.bin == 8'h00 || $past(load)))
        else $error("carry without a step or without a wrap to zero");

endmodule

// File: src/rtc_alarm.sv
`timescale 1ns/100ps

module rtc_alarm import rtc_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        binary_mode,
    input  logic       [NUM_FIELDS-1:0] alarm_load,
    input  time_byte_t                  load_data,
    input  time_byte_t [NUM_FIELDS-1:0] field_value,
    input  time_byte_t [NUM_FIELDS-1:0] field_next,
    input  logic       [NUM_FIELDS-1:0] field_step,
    output time_byte_t [NUM_FIELDS-1:0] alarm_value,
    output logic                        alarm_hit
);

    logic [NUM_FIELDS-1:0] match;

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            if (!rst_n) begin
                alarm_value[i] <= '0;
            end else if (alarm_load[i]) begin
                alarm_value[i] <= load_data;
            end
        end
    end

    // a stepping field is compared with the value it is about to take.
    always_comb begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            if (alarm_value[i].bin[7:6] == ALARM_WILDCARD) begin
                match[i] = 1'b1;
            end else if (field_step[i]) begin
                match[i] = (field_next[i].bin == alarm_value[i].bin);
            end else begin
                match[i] = (field_value[i].bin == alarm_value[i].bin);
            end
        end
    end

    assign alarm_hit = field_step[0] && (&match);   // only ever on a seconds step.

endmodule

// File: src/rtc_periodic.sv
`timescale 1ns/100ps

module rtc_periodic (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick_8192,
    input  logic [2:0] divider,
    input  logic [3:0] rate,
    output logic       periodic_hit
);

    logic enabled;
    logic [12:0] period;
    logic [12:0] count;

    assign enabled = (rate != 4'd0) && (divider[2:1] != 2'b00);

    // period in 8192 Hz ticks.
    always_comb begin
        case (rate)
            4'd0:    period = 13'd0;
            4'd1:    period = 13'd32;
            4'd2:    period = 13'd64;
            default: period = 13'd1 << (rate - 4'd3);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !enabled) begin
            count <= '0;
        end else if (tick_8192) begin
            if (count <= 13'd1) begin
                count <= period;    // zero after enable just loads, one fires.
            end else begin
                count <= count - 13'd1;
            end
        end
    end

    assign periodic_hit = enabled && tick_8192 && (count == 13'd1);

    a_hit_reload: assert property (@(posedge clk) disable iff (!rst_n)
        periodic_hit |-> tick_8192 ##1 (count == $past(period)))
        else $error("periodic hit off tick or without a reload");

endmodule

// File: src/rtc_regs.sv
`timescale 1ns/100ps

module rtc_regs import rtc_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        io_address,
    input  logic                        io_read,
    input  logic                        io_write,
    input  logic                  [7:0] io_writedata,
    output logic                  [7:0] io_readdata,
    output logic                        irq,
    input  time_byte_t [NUM_FIELDS-1:0] field_value,
    input  time_byte_t [NUM_FIELDS-1:0] alarm_value,
    output logic       [NUM_FIELDS-1:0] field_load,
    output logic       [NUM_FIELDS-1:0] alarm_load,
    output time_byte_t                  load_data,
    output logic                        binary_mode,
    output logic                        halt,
    output logic                  [2:0] divider,
    output logic                  [3:0] periodic_rate,
    input  logic                        second_start,
    input  logic                        update_busy,
    input  logic                        alarm_hit,
    input  logic                        periodic_hit
);

    localparam logic [6:0] FIELD_REG [NUM_FIELDS] = '{REG_SECONDS, REG_MINUTES, REG_HOURS};
    localparam logic [6:0] ALARM_REG [NUM_FIELDS] =
        '{REG_ALARM_SECONDS, REG_ALARM_MINUTES, REG_ALARM_HOURS};

    logic [6:0] index;
    logic read_seen;
    logic read_valid;
    logic data_write;
    logic clear_c;
    logic freeze;
    logic pie;
    logic aie;
    logic uie;
    logic pf;
    logic af;
    logic uf;
    logic int_pending;
    logic [7:0] read_mux;

    assign read_valid = io_read && !read_seen;     // first cycle of a read only.
    assign data_write = io_write && io_address;
    assign clear_c = read_valid && io_address && (index == REG_C);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_seen <= 1'b0;
            index <= '0;
        end else begin
            read_seen <= io_read;
            if (io_write && !io_address) begin
                index <= io_writedata[6:0];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
            field_load[i] = data_write && (index == FIELD_REG[i]);
            alarm_load[i] = data_write && (index == ALARM_REG[i]);
        end
    end

    assign load_data = io_writedata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            divider <= '0;
            periodic_rate <= '0;
            freeze <= 1'b0;
            pie <= 1'b0;
            aie <= 1'b0;
            uie <= 1'b0;
            binary_mode <= 1'b0;
        end else if (data_write && index == REG_A) begin
            divider <= io_writedata[6:4];
            periodic_rate <= io_writedata[3:0];
        end else if (data_write && index == REG_B) begin
            freeze <= io_writedata[7];
            pie <= io_writedata[6];
            aie <= io_writedata[5];
            uie <= io_writedata[4] && !io_writedata[7];    // no update irq while setting time.
            binary_mode <= io_writedata[2];
        end
    end

    assign halt = freeze || (divider[2:1] == DIVIDER_STOP);

    // a new event in the clearing cycle survives the clear.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pf <= 1'b0;
            af <= 1'b0;
            uf <= 1'b0;
        end else begin
            pf <= (pf && !clear_c) || periodic_hit;
            af <= (af && !clear_c) || alarm_hit;
            uf <= (uf && !clear_c) || second_start;
        end
    end

    assign int_pending = (pie && pf) || (aie && af) || (uie && uf);

    always_ff @(posedge clk) begin
        if (!rst_n || clear_c) begin
            irq <= 1'b0;
        end else if (!irq && int_pending) begin
            irq <= 1'b1;
        end
    end

    always_comb begin
        case (index)
            REG_SECONDS:       read_mux = field_value[0].bin;
            REG_ALARM_SECONDS: read_mux = alarm_value[0].bin;
            REG_MINUTES:       read_mux = field_value[1].bin;
            REG_ALARM_MINUTES: read_mux = alarm_value[1].bin;
            REG_HOURS:         read_mux = field_value[2].bin;
            REG_ALARM_HOURS:   read_mux = alarm_value[2].bin;
            REG_A:             read_mux = {update_busy, divider, periodic_rate};
            REG_B:             read_mux = {freeze, pie, aie, uie, 1'b0, binary_mode, 2'b10};
            REG_C:             read_mux = {irq, pf, af, uf, 4'h0};
            REG_D:             read_mux = REG_D_VALUE;
            default:           read_mux = 8'h00;
        endcase
    end

    // flags are captured before the clear of the same read lands.
    always_ff @(posedge clk) begin
        if (read_valid) begin
            io_readdata <= io_address ? read_mux : 8'hFF;
        end
    end

    a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> $past(int_pending))
        else $error("irq raised without an enabled flag");

endmodule

// File: src/rtc_top.sv
`timescale 1ns/100ps

module rtc_top import rtc_pkg::*; #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       io_address,
    input  logic       io_read,
    input  logic       io_write,
    input  logic [7:0] io_writedata,
    output logic [7:0] io_readdata,
    output logic       irq
);

    logic tick_800;
    logic tick_8192;
    logic second_start;
    logic update_busy;
    logic halt;
    logic binary_mode;
    logic [2:0] divider;
    logic [3:0] periodic_rate;
    logic alarm_hit;
    logic periodic_hit;

    logic [NUM_FIELDS-1:0] field_load;
    logic [NUM_FIELDS-1:0] alarm_load;
    logic [NUM_FIELDS-1:0] step;
    logic [NUM_FIELDS-1:0] carry;       // top bit is the midnight rollover.
    time_byte_t load_data;
    time_byte_t [NUM_FIELDS-1:0] field_value;
    time_byte_t [NUM_FIELDS-1:0] field_next;
    time_byte_t [NUM_FIELDS-1:0] alarm_value;

    // seconds step on the update pulse, each higher field on the carry below it.
    assign step = {carry[NUM_FIELDS-2:0], second_start};

    rtc_tick_gen #(.CLK_HZ(CLK_HZ)) u_tick_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick_800  (tick_800),
        .tick_8192 (tick_8192)
    );

    rtc_update_ctrl u_update_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .halt         (halt),
        .tick_800     (tick_800),
        .second_start (second_start),
        .update_busy  (update_busy)
    );

    for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_field
        rtc_field_counter #(.MAX_BIN(FIELD_MAX[i])) u_field (
            .clk         (clk),
            .rst_n       (rst_n),
            .binary_mode (binary_mode),
            .step        (step[i]),
            .load        (field_load[i]),
            .load_data   (load_data),
            .value       (field_value[i]),
            .next_value  (field_next[i]),
            .carry       (carry[i])
        );
    end

    rtc_alarm u_alarm (
        .clk         (clk),
        .rst_n       (rst_n),
        .binary_mode (binary_mode),
        .alarm_load  (alarm_load),
        .load_data   (load_data),
        .field_value (field_value),
        .field_next  (field_next),
        .field_step  (step),
        .alarm_value (alarm_value),
        .alarm_hit   (alarm_hit)
    );

    rtc_periodic u_periodic (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick_8192    (tick_8192),
        .divider      (divider),
        .rate         (periodic_rate),
        .periodic_hit (periodic_hit)
    );

    rtc_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .io_address    (io_address),
        .io_read       (io_read),
        .io_write      (io_write),
        .io_writedata  (io_writedata),
        .io_readdata   (io_readdata),
        .irq           (irq),
        .field_value   (field_value),
        .alarm_value   (alarm_value),
        .field_load    (field_load),
        .alarm_load    (alarm_load),
        .load_data     (load_data),
        .binary_mode   (binary_mode),
        .halt          (halt),
        .divider       (divider),
        .periodic_rate (periodic_rate),
        .second_start  (second_start),
        .update_busy   (update_busy),
        .alarm_hit     (alarm_hit),
        .periodic_hit  (periodic_hit)
    );

endmodule

// File: verification/rtc_tb.sv
`timescale 1ns/100ps

module rtc_tb;

    localparam int CLK_HZ = 16384;
    localparam int TIMEOUT = 40000;     // cycles allowed for any single wait.
    localparam int MAX_CMDS = 128;

    logic clk;
    logic rst_n;
    logic io_address;
    logic io_read;
    logic io_write;
    logic [7:0] io_writedata;
    logic [7:0] io_readdata;
    logic irq;

    logic [31:0] cmds [MAX_CMDS];
    int checks;
    int errors;
    int tests;
    int test_checks;
    int test_errors;

    rtc_top #(.CLK_HZ(CLK_HZ)) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .irq          (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one write strobe on the index or data port.
    task automatic strobe_port(input logic addr, input logic [7:0] data);
        @(negedge clk);
        io_address = addr;
        io_writedata = data;
        io_write = 1'b1;
        @(negedge clk);
        io_write = 1'b0;
    endtask

    task automatic write_register(input logic [6:0] index, input logic [7:0] data);
        strobe_port(1'b0, {1'b0, index});
        strobe_port(1'b1, data);
    endtask

    task automatic read_register(input logic [6:0] index, output logic [7:0] data);
        strobe_port(1'b0, {1'b0, index});
        io_address = 1'b1;
        io_read = 1'b1;
        @(negedge clk);
        io_read = 1'b0;
        data = io_readdata;     // registered on the edge that saw the read.
    endtask

    task automatic check_read(input logic [6:0] index, input logic [7:0] expected);
        logic [7:0] actual;
        read_register(index, actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            $display("ERR %0t io_readdata (reg 0x%02h) expected 0x%02h actual 0x%02h",
                     $time, index, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_irq(input logic expected);
        @(negedge clk);
        checks++;
        test_checks++;
        if (irq !== expected) begin
            $display("ERR %0t irq expected %b actual %b", $time, expected, irq);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_irq(output bit ok);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = (irq === 1'b1);
    endtask

    task automatic idle(input int count, output bit ok);
        int n;
        n = 0;
        while (n < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = (count <= TIMEOUT);
    endtask

    initial begin
        int pc;
        logic [31:0] cmd;
        logic [7:0] scratch;
        bit ok;
        bit stop;
        rst_n = 1'b0;
        io_address = 1'b0;
        io_read = 1'b0;
        io_write = 1'b0;
        io_writedata = 8'h00;
        checks = 0;
        errors = 0;
        tests = 0;
        test_checks = 0;
        test_errors = 0;
        stop = 1'b0;
        $readmemh("verification/rtc_stimulus.txt", cmds);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        pc = 0;
        while (!stop && pc < MAX_CMDS) begin
            cmd = cmds[pc];
            if ($isunknown(cmd)) begin
                $display("stimulus command %0d is missing or unreadable", pc);
                errors++;
                stop = 1'b1;
            end else begin
                case (cmd[31:28])
                    4'h0: stop = 1'b1;                  // end of list.
                    4'h1: write_register(cmd[22:16], cmd[7:0]);
                    4'h2: check_read(cmd[22:16], cmd[7:0]);
                    4'h3: begin
                        wait_irq(ok);
                        if (!ok) begin
                            $display("irq did not rise within %0d cycles at command %0d",
                                     TIMEOUT, pc);
                            errors++;
                            stop = 1'b1;
                        end
                    end
                    4'h4: begin
                        idle(int'(cmd[15:0]), ok);
                        if (!ok) begin
                            $display("wait at command %0d is longer than the timeout", pc);
                            errors++;
                        end
                    end
                    4'h5: check_irq(cmd[0]);
                    4'h6: read_register(cmd[22:16], scratch);   // clears register C.
                    4'hE: begin
                        tests++;
                        $display("test %0d %s: %0d checks, %0d errors", tests,
                                 (test_errors == 0) ? "passed" : "failed",
                                 test_checks, test_errors);
                        test_checks = 0;
                        test_errors = 0;
                    end
                    default: begin
                        $display("unknown command 0x%08h at line %0d of the stimulus", cmd, pc);
                        errors++;
                        stop = 1'b1;
                    end
                endcase
            end
            pc++;
        end
        if (!stop) begin
            $display("stimulus list has no end command");
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verification/rtc_stimulus.txt
// word: op[31:28] 0[27:24] index[23:16] value or cycle count[15:0]
// op 1 write, 2 read and compare, 3 wait irq, 4 wait cycles, 5 check irq, 6 read only, E test end, 0 stop
50000000 // reset state
200C0000
200D0080
E0000000
100B0080 // BCD rollover, freeze first
10000058
10020059
10040023
600C0000
100B0010
30000000
200C0090
20000059
50000000
30000000
20040000
20020000
20000000
200C00B0 // zero alarms match at midnight
E0000000
100B0084 // binary mode
1000003B
1002003B
10040017
600C0000
100B0014
30000000
200C00B0
20040000
20020000
20000000
10000009
30000000
200C0090
2000000A
E0000000
100500C0 // alarm on the next second
100300C0
1001000B
100B0024
30000000
200C00B0
E0000000
100A0023 // periodic every tick
100B0044
30000000
200C00C0
100A0003
600C0000
400003E8
200C0000
50000000
E0000000
100B0090 // freeze drops UIE
200B0082
10000030
20000030
40004E20
20000030
200A0003
E0000000
00000000

// File: build.f
common/rtc_pkg.sv
src/rtc_tick_gen.sv
src/rtc_update_ctrl.sv
src/rtc_field_counter.sv
src/rtc_alarm.sv
src/rtc_periodic.sv
src/rtc_regs.sv
src/rtc_top.sv
verification/rtc_tb.sv
